// File: hdl/i3c_pkg.sv
package i3c_pkg;

  // Broadcast address, sent with the read bit to open ENTDAA
  localparam logic [6:0] RsvdAddr = 7'h7E;

  // Provisional ID width
  localparam int unsigned IdWidth = 48;

  // Single-cycle bus condition flags
  typedef struct packed {
    logic start;
    logic rstart;
    logic stop;
  } bus_event_t;

  // Request levels towards the receiver
  typedef struct packed {
    logic req_bit;
    logic req_byte;
  } rx_req_t;

  // Request levels towards the transmitter
  typedef struct packed {
    logic       req_bit;
    logic       req_byte;
    logic [7:0] value;
    logic       sel_od_pp;
  } tx_req_t;

  // arbitration_lost is only meaningful together with done
  typedef struct packed {
    logic done;
    logic arbitration_lost;
  } tx_status_t;

endpackage

// File: hdl/bus_monitor.sv
`timescale 1ns/1ns

module bus_monitor
  import i3c_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  output bus_event_t events_o
);

  logic       scl_q;
  logic       sda_q;
  logic       busy_q;
  logic       start_det;
  logic       stop_det;
  bus_event_t events_q;

  // SDA edge with SCL high on both samples
  assign start_det = scl_q && scl_i && sda_q && !sda_i;
  assign stop_det  = scl_q && scl_i && !sda_q && sda_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q    <= 1'b1;
      sda_q    <= 1'b1;
      busy_q   <= 1'b0;
      events_q <= '0;
    end else begin
      scl_q           <= scl_i;
      sda_q           <= sda_i;
      events_q.start  <= start_det && !busy_q;
      events_q.rstart <= start_det && busy_q;
      events_q.stop   <= stop_det;
      if (stop_det) begin
        busy_q <= 1'b0;
      end else if (start_det) begin
        busy_q <= 1'b1;
      end
    end
  end

  assign events_o = events_q;

  // A bus condition is never followed by another one in the next cycle
  start_stop_exclusive_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (events_o.start || events_o.rstart || events_o.stop) |=> (events_o == '0)
  );

endmodule

// File: hdl/bus_rx.sv
`timescale 1ns/1ns

module bus_rx
  import i3c_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  input  rx_req_t    req_i,
  output logic [7:0] data_o,
  output logic       done_o
);

  logic       scl_q;
  logic       active_q;
  logic       done_q;
  logic [3:0] count_q;
  logic [7:0] shift_q;
  logic       req_act;
  logic       load;
  logic       scl_rise;
  logic       scl_fall;

  assign req_act  = req_i.req_bit || req_i.req_byte;
  assign scl_rise = scl_i && !scl_q;
  assign scl_fall = !scl_i && scl_q;

  // No restart in the done cycle while the old request is still up
  assign load = !active_q && req_act && !scl_i && !done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q    <= 1'b1;
      active_q <= 1'b0;
      done_q   <= 1'b0;
      count_q  <= '0;
    end else begin
      scl_q  <= scl_i;
      done_q <= 1'b0;
      if (load) begin
        active_q <= 1'b1;
        count_q  <= req_i.req_byte ? 4'd8 : 4'd1;
      end else if (active_q && !req_act) begin
        // Request withdrawn on STOP
        active_q <= 1'b0;
      end else if (active_q && scl_rise) begin
        count_q <= count_q - 4'd1;
      end else if (active_q && scl_fall && count_q == '0) begin
        active_q <= 1'b0;
        done_q   <= 1'b1;
      end
    end
  end

  // MSB first; a single bit ends up in bit 0
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= '0;
    end else if (active_q && scl_rise) begin
      shift_q <= {shift_q[6:0], sda_i};
    end
  end

  assign data_o = shift_q;
  assign done_o = done_q;

endmodule

// File: hdl/bus_tx.sv
`timescale 1ns/1ns

module bus_tx
  import i3c_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       scl_i,
  input  logic       sda_i,
  input  tx_req_t    req_i,
  output tx_status_t status_o,
  output logic       sda_oe_o,
  output logic       sel_od_pp_o
);

  typedef enum logic [1:0] {
    Idle,
    Setup,
    High,
    Next
  } tx_phase_e;

  tx_phase_e  phase_q;
  logic       scl_q;
  logic       oe_q;
  logic       lost_q;
  logic       done_q;
  logic       sel_q;
  logic [3:0] count_q;
  logic [7:0] shift_q;
  logic       req_act;
  logic       load;
  logic       scl_rise;
  logic       scl_fall;

  assign req_act  = req_i.req_bit || req_i.req_byte;
  assign scl_rise = scl_i && !scl_q;
  assign scl_fall = !scl_i && scl_q;
  assign load     = (phase_q == Idle) && req_act && !scl_i && !done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= Idle;
      scl_q   <= 1'b1;
      oe_q    <= 1'b0;
      lost_q  <= 1'b0;
      done_q  <= 1'b0;
      sel_q   <= 1'b0;
      count_q <= '0;
    end else begin
      scl_q  <= scl_i;
      done_q <= 1'b0;
      if (phase_q != Idle && !req_act) begin
        // Abort and let go of the bus
        phase_q <= Idle;
        oe_q    <= 1'b0;
      end else begin
        unique case (phase_q)
          Idle: begin
            if (load) begin
              phase_q <= Setup;
              count_q <= req_i.req_byte ? 4'd8 : 4'd1;
              lost_q  <= 1'b0;
              sel_q   <= req_i.sel_od_pp;
            end
          end
          Setup: begin
            if (scl_rise) begin
              phase_q <= High;
              // Released bit but the bus reads low
              if (shift_q[7] && !lost_q && !sda_i) begin
                lost_q <= 1'b1;
              end
            end else if (!scl_i) begin
              oe_q <= !shift_q[7] && !lost_q;
            end
          end
          High: begin
            if (scl_fall) begin
              if (count_q == 4'd1) begin
                phase_q <= Idle;
                oe_q    <= 1'b0;
                done_q  <= 1'b1;
              end else begin
                phase_q <= Next;
              end
            end
          end
          Next: begin
            count_q <= count_q - 4'd1;
            phase_q <= Setup;
          end
          default: begin
            phase_q <= Idle;
          end
        endcase
      end
    end
  end

  // A single bit goes out from the MSB position
  always_ff @(posedge clk_i) begin
    if (load) begin
      shift_q <= req_i.req_byte ? req_i.value : {req_i.value[0], 7'b0};
    end else if (phase_q == Next) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end
  end

  assign status_o.done             = done_q;
  assign status_o.arbitration_lost = lost_q;
  assign sda_oe_o                  = oe_q;
  assign sel_od_pp_o               = sel_q;

  // Driver only moves while SCL is low
  oe_stable_scl_high_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (scl_i && $past(scl_i)) |-> $stable(sda_oe_o)
  );

endmodule

// File: hdl/ccc_entdaa.sv
`timescale 1ns/1ns

module ccc_entdaa
  import i3c_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic [IdWidth-1:0] id_i,
  input  logic               start_daa_i,
  input  bus_event_t         events_i,
  input  logic [7:0]         rx_data_i,
  input  logic               rx_done_i,
  output rx_req_t            rx_req_o,
  input  tx_status_t         tx_status_i,
  output tx_req_t            tx_req_o,
  output logic               done_daa_o,
  output logic [7:0]         address_o,
  output logic               address_valid_o
);

  typedef enum logic [3:0] {
    Idle,
    WaitStart,
    ReceiveRsvdByte,
    AckRsvdByte,
    SendNack,
    SendID,
    PrepareIDBit,
    SendIDBit,
    LostArbitration,
    ReceiveAddr,
    AckAddr,
    Done,
    Error
  } daa_state_e;

  daa_state_e state_q;
  daa_state_e state_d;
  logic [5:0] id_bit_count_q;
  logic       load_id_count;
  logic       tick_id_count;
  logic       rsvd_byte_det;
  logic       parity_ok;
  logic [6:0] address_q;
  logic       address_valid_q;

  assign rsvd_byte_det = (rx_data_i == {RsvdAddr, 1'b1});
  // Odd number of ones over the whole byte
  assign parity_ok     = ^rx_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      id_bit_count_q <= '0;
    end else if (load_id_count) begin
      id_bit_count_q <= 6'(IdWidth);
    end else if (tick_id_count) begin
      id_bit_count_q <= id_bit_count_q - 6'd1;
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (start_daa_i) begin
          state_d = WaitStart;
        end
      end
      WaitStart: begin
        // Plain START too in case the first one was missed
        if (events_i.rstart || events_i.start) begin
          state_d = ReceiveRsvdByte;
        end
      end
      ReceiveRsvdByte: begin
        if (rx_done_i) begin
          state_d = rsvd_byte_det ? AckRsvdByte : SendNack;
        end
      end
      AckRsvdByte: begin
        if (tx_status_i.done) begin
          state_d = SendID;
        end
      end
      SendNack: begin
        if (tx_status_i.done) begin
          state_d = Error;
        end
      end
      SendID: begin
        state_d = PrepareIDBit;
      end
      PrepareIDBit: begin
        state_d = SendIDBit;
      end
      SendIDBit: begin
        if (tx_status_i.done) begin
          if (tx_status_i.arbitration_lost) begin
            state_d = LostArbitration;
          end else if (id_bit_count_q == '0) begin
            state_d = ReceiveAddr;
          end else begin
            state_d = PrepareIDBit;
          end
        end
      end
      ReceiveAddr: begin
        if (rx_done_i) begin
          state_d = parity_ok ? AckAddr : SendNack;
        end
      end
      AckAddr: begin
        // Address assigned so stay off the bus from here on
        if (tx_status_i.done) begin
          state_d = Idle;
        end
      end
      Done: begin
        if (start_daa_i) begin
          state_d = WaitStart;
        end
      end
      // LostArbitration and Error wait for STOP
      default: begin
      end
    endcase
  end

  always_comb begin
    rx_req_o      = '0;
    tx_req_o      = '0;
    load_id_count = 1'b0;
    tick_id_count = 1'b0;
    unique case (state_q)
      ReceiveRsvdByte: begin
        rx_req_o.req_byte = 1'b1;
      end
      AckRsvdByte: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 8'h00;
      end
      SendNack: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 8'hFF;
      end
      SendID: begin
        load_id_count = 1'b1;
      end
      PrepareIDBit: begin
        tick_id_count = 1'b1;
      end
      SendIDBit: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = {7'b0, id_i[id_bit_count_q]};
      end
      ReceiveAddr: begin
        rx_req_o.req_byte = 1'b1;
      end
      AckAddr: begin
        tx_req_o.req_bit = 1'b1;
        tx_req_o.value   = 8'h00;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else if (events_i.stop) begin
      state_q <= Done;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      address_q       <= '0;
      address_valid_q <= 1'b0;
    end else begin
      if (state_q == ReceiveAddr && rx_done_i && parity_ok) begin
        address_q <= rx_data_i[7:1];
      end
      if (start_daa_i) begin
        address_valid_q <= 1'b0;
      end else if (state_q == AckAddr && tx_status_i.done) begin
        address_valid_q <= 1'b1;
      end
    end
  end

  assign done_daa_o      = (state_q == Done);
  assign address_o       = {1'b0, address_q};
  assign address_valid_o = address_valid_q;

  // An rx request never overlaps a tx request or the tx done pulse
  rx_tx_exclusive_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (rx_req_o.req_bit || rx_req_o.req_byte) |->
      !(tx_req_o.req_bit || tx_req_o.req_byte || tx_status_i.done)
  );

endmodule

// File: hdl/i3c_daa_target.sv
`timescale 1ns/1ns

module i3c_daa_target
  import i3c_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               scl_i,
  input  logic               sda_i,
  input  logic [IdWidth-1:0] id_i,
  input  logic               start_daa_i,
  output logic               sda_oe_o,
  output logic               sel_od_pp_o,
  output logic               done_daa_o,
  output logic [7:0]         address_o,
  output logic               address_valid_o
);

  bus_event_t events;
  rx_req_t    rx_req;
  logic [7:0] rx_data;
  logic       rx_done;
  tx_req_t    tx_req;
  tx_status_t tx_status;

  bus_monitor bus_monitor_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .scl_i    (scl_i),
    .sda_i    (sda_i),
    .events_o (events)
  );

  bus_rx bus_rx_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .req_i  (rx_req),
    .data_o (rx_data),
    .done_o (rx_done)
  );

  bus_tx bus_tx_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .scl_i       (scl_i),
    .sda_i       (sda_i),
    .req_i       (tx_req),
    .status_o    (tx_status),
    .sda_oe_o    (sda_oe_o),
    .sel_od_pp_o (sel_od_pp_o)
  );

  ccc_entdaa ccc_entdaa_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .id_i            (id_i),
    .start_daa_i     (start_daa_i),
    .events_i        (events),
    .rx_data_i       (rx_data),
    .rx_done_i       (rx_done),
    .rx_req_o        (rx_req),
    .tx_status_i     (tx_status),
    .tx_req_o        (tx_req),
    .done_daa_o      (done_daa_o),
    .address_o       (address_o),
    .address_valid_o (address_valid_o)
  );

endmodule

// File: tb/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period, reset held for 8 cycles
  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #2 clk_o = ~clk_o;

endmodule

// File: tb/tb_i3c_daa_target.sv
`timescale 1ns/1ns

module tb_i3c_daa_target
  import i3c_pkg::*;
();

  logic               clk_i;
  logic               rst_ni;
  logic               scl_m;
  logic               sda_m;
  logic               sda_bus;
  logic [IdWidth-1:0] id_val;
  logic               start_daa;
  logic               sda_oe;
  logic               sel_od_pp;
  logic               done_daa;
  logic [7:0]         address;
  logic               address_valid;

  // Checker controls driven by the bus model
  logic        sample_q;
  logic        expect_chk;
  logic        expect_sda;
  logic        expect_released;
  logic        idle_chk;
  logic        win_chk;
  logic        no_valid_chk;
  logic        stop_chk;
  logic [6:0]  exp_addr;
  int unsigned errors;
  int unsigned timeouts;

  clk_gen clk_gen_i (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  // Open-drain bus where low wins
  assign sda_bus = sda_m && !sda_oe;

  i3c_daa_target i3c_daa_target_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scl_i           (scl_m),
    .sda_i           (sda_bus),
    .id_i            (id_val),
    .start_daa_i     (start_daa),
    .sda_oe_o        (sda_oe),
    .sel_od_pp_o     (sel_od_pp),
    .done_daa_o      (done_daa),
    .address_o       (address),
    .address_valid_o (address_valid)
  );

  task automatic flag_mismatch(input string msg);
    errors++;
    $display("mismatch at %0t ns: %s", $time, msg);
  endtask

  task automatic cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic await_reset(input int limit);
    int n;
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
    end while (rst_ni !== 1'b1 && n < limit);
    if (rst_ni !== 1'b1) begin
      timeouts++;
      $display("timeout: reset was not released within %0d cycles", limit);
    end
  endtask

  task automatic await_done_daa(input int limit);
    int n;
    n = 0;
    while (done_daa !== 1'b1 && n < limit) begin
      @(posedge clk_i);
      n++;
    end
    if (done_daa !== 1'b1) begin
      timeouts++;
      $display("timeout: done_daa_o did not rise within %0d cycles of STOP", limit);
    end
  endtask

  // One SCL period, starting and ending with SCL low
  task automatic clock_bit(input logic drive, input logic chk, input logic level);
    cycles(4);
    sda_m <= drive;
    cycles(4);
    scl_m      <= 1'b1;
    expect_chk <= chk;
    expect_sda <= level;
    cycles(4);
    sample_q <= 1'b1;
    cycles(1);
    sample_q <= 1'b0;
    cycles(3);
    scl_m <= 1'b0;
  endtask

  task automatic bus_start();
    cycles(1);
    sda_m <= 1'b0;
    cycles(4);
    scl_m <= 1'b0;
  endtask

  task automatic bus_rstart();
    cycles(4);
    sda_m <= 1'b1;
    cycles(4);
    scl_m <= 1'b1;
    cycles(4);
    sda_m <= 1'b0;
    cycles(4);
    scl_m <= 1'b0;
  endtask

  task automatic bus_stop();
    cycles(4);
    sda_m <= 1'b0;
    cycles(4);
    scl_m <= 1'b1;
    cycles(4);
    sda_m <= 1'b1;
    cycles(4);
  endtask

  task automatic send_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], 1'b0, 1'b1);
    end
  endtask

  // Odd parity over address and parity bit together
  task automatic send_address(input logic [6:0] addr, input logic good_parity);
    logic par;
    par = good_parity ? ~^addr : ^addr;
    for (int i = 6; i >= 0; i--) begin
      clock_bit(addr[i], 1'b0, 1'b1);
    end
    clock_bit(par, 1'b0, 1'b1);
  endtask

  // START, ENTDAA trigger, Sr, broadcast byte and its ACK slot
  task automatic open_daa(input logic [7:0] first_byte, input logic ack);
    bus_start();
    cycles(2);
    start_daa <= 1'b1;
    cycles(1);
    start_daa <= 1'b0;
    bus_rstart();
    send_byte(first_byte);
    clock_bit(1'b1, 1'b1, !ack);
  endtask

  idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle_chk |-> !sda_oe && !done_daa && !address_valid && sda_bus)
    else flag_mismatch("outputs or SDA not idle after reset");

  od_mode_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !sel_od_pp)
    else flag_mismatch("SDA driver not in open-drain mode");

  sda_level_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sample_q && expect_chk) |-> sda_bus == expect_sda)
    else flag_mismatch("SDA level wrong at SCL high");

  released_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    expect_released |-> !sda_oe)
    else flag_mismatch("target drives SDA where it must stay off the bus");

  address_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (win_chk && $rose(done_daa)) |-> address_valid && address == {1'b0, exp_addr})
    else flag_mismatch("assigned address wrong or not valid at STOP");

  no_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    no_valid_chk |-> !address_valid)
    else flag_mismatch("address_valid_o high without an assigned address");

  stop_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stop_chk |-> done_daa && !sda_oe)
    else flag_mismatch("STOP did not end the DAA or SDA still driven");

  start_clear_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_daa |=> !done_daa && !address_valid)
    else flag_mismatch("start_daa_i did not clear done and address valid");

  initial begin
    logic [7:0] bad_byte;
    logic [6:0] addr;
    int         lose_idx;
    int         stop_idx;

    scl_m           = 1'b1;
    sda_m           = 1'b1;
    start_daa       = 1'b0;
    id_val          = '0;
    sample_q        = 1'b0;
    expect_chk      = 1'b0;
    expect_sda      = 1'b1;
    expect_released = 1'b0;
    idle_chk        = 1'b0;
    win_chk         = 1'b0;
    no_valid_chk    = 1'b0;
    stop_chk        = 1'b0;
    exp_addr        = '0;
    errors          = 0;
    timeouts        = 0;
    void'($urandom(32'ha98716e3));

    await_reset(40);
    idle_chk <= 1'b1;
    cycles(16);
    idle_chk <= 1'b0;

    // Winning DAA
    id_val <= {16'($urandom()), $urandom()};
    addr = 7'($urandom());
    exp_addr <= addr;
    open_daa({7'h7E, 1'b1}, 1'b1);
    for (int i = IdWidth - 1; i >= 0; i--) begin
      clock_bit(1'b1, 1'b1, id_val[i]);
    end
    send_address(addr, 1'b1);
    clock_bit(1'b1, 1'b1, 1'b0);
    win_chk <= 1'b1;
    bus_stop();
    await_done_daa(8);
    win_chk <= 1'b0;

    // Wrong broadcast byte gets NACK and no ID
    bad_byte = 8'($urandom());
    if (bad_byte == {7'h7E, 1'b1}) begin
      bad_byte = 8'h00;
    end
    open_daa(bad_byte, 1'b0);
    no_valid_chk    <= 1'b1;
    expect_released <= 1'b1;
    send_byte(8'($urandom()));
    bus_stop();
    cycles(4);
    no_valid_chk    <= 1'b0;
    expect_released <= 1'b0;

    // Even parity on the address
    open_daa({7'h7E, 1'b1}, 1'b1);
    no_valid_chk <= 1'b1;
    for (int i = IdWidth - 1; i >= 0; i--) begin
      clock_bit(1'b1, 1'b1, id_val[i]);
    end
    send_address(addr, 1'b0);
    clock_bit(1'b1, 1'b1, 1'b1);
    bus_stop();
    cycles(4);
    no_valid_chk <= 1'b0;

    // Another target wins at a 1 bit
    lose_idx = int'($urandom() % IdWidth);
    id_val[lose_idx] <= 1'b1;
    open_daa({7'h7E, 1'b1}, 1'b1);
    no_valid_chk <= 1'b1;
    for (int i = IdWidth - 1; i >= 0; i--) begin
      if (i > lose_idx) begin
        clock_bit(1'b1, 1'b1, id_val[i]);
      end else if (i == lose_idx) begin
        clock_bit(1'b0, 1'b0, 1'b0);
        expect_released <= 1'b1;
      end else begin
        clock_bit(1'($urandom()), 1'b0, 1'b0);
      end
    end
    send_address(7'($urandom()), 1'b1);
    clock_bit(1'b1, 1'b1, 1'b1);
    bus_stop();
    cycles(4);
    no_valid_chk    <= 1'b0;
    expect_released <= 1'b0;

    // STOP in the middle of the ID at a slot where the target releases
    stop_idx = 1 + int'($urandom() % (IdWidth - 2));
    id_val[stop_idx] <= 1'b1;
    open_daa({7'h7E, 1'b1}, 1'b1);
    for (int i = IdWidth - 1; i > stop_idx; i--) begin
      clock_bit(1'b1, 1'b1, id_val[i]);
    end
    bus_stop();
    await_done_daa(8);
    stop_chk <= 1'b1;
    cycles(4);
    stop_chk  <= 1'b0;
    start_daa <= 1'b1;
    cycles(1);
    start_daa <= 1'b0;
    cycles(4);

    $display("checks complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: project.f
hdl/i3c_pkg.sv
hdl/bus_monitor.sv
hdl/bus_rx.sv
hdl/bus_tx.sv
hdl/ccc_entdaa.sv
hdl/i3c_daa_target.sv
tb/clk_gen.sv
tb/tb_i3c_daa_target.sv

// File: Bender.yml
package:
  name: i3c_daa_target

sources:
  - files:
      - hdl/i3c_pkg.sv
      - hdl/bus_monitor.sv
      - hdl/bus_rx.sv
      - hdl/bus_tx.sv
      - hdl/ccc_entdaa.sv
      - hdl/i3c_daa_target.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/tb_i3c_daa_target.sv
